// File: bitmanip_pkg.sv
`default_nettype none

package bitmanip_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_HAMMING  = 3'd0,  // popcount of a ^ b
        OP_POPCOUNT = 3'd1,
        OP_PACK     = 3'd2,  // {b[15:0], a[15:0]}
        OP_REV8     = 3'd3,
        OP_SH1ADD   = 3'd4,  // (a << 1) + b
        OP_CTZ      = 3'd5   // 32 for zero input
    } op_e;                  // 6 and 7 are refused by the register block

    // control word, written raw and decoded into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [22:0] unused_hi;
            logic        start;      // bit 8, self clearing
            logic [4:0]  unused_lo;
            op_e         op;         // bits 2:0
        } f;
    } ctrl_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] REG_OP_A   = 8'h00;
    localparam logic [7:0] REG_OP_B   = 8'h04;
    localparam logic [7:0] REG_CTRL   = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_RESULT = 8'h10;

    // status word bits
    localparam int unsigned STATUS_BUSY = 0;
    localparam int unsigned STATUS_DONE = 1;

endpackage

`default_nettype wire

// File: bit_count.sv
`timescale 1ns/1ps
`default_nettype none

module bit_count (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire  [31:0] data_i,
    input  wire         start_i,
    output logic [5:0]  count_o,
    output logic        valid_o
);

    logic [31:0] fields3;   // bit count per 3-bit field
    logic [31:0] sums6;     // pairs folded into 6-bit groups
    logic [31:0] stage1_q;
    logic        stage1_vld_q;
    logic [5:0]  fold;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1, octal partial sums
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fields3 = data_i - ((data_i >> 1) & 32'hdb6d_b6db) - ((data_i >> 2) & 32'h4924_9249);
    assign sums6   = (fields3 + (fields3 >> 3)) & 32'hc71c_71c7;

    // base-64 digit sum, i.e. mod 63, exact while the total stays below 63
    assign fold = stage1_q[5:0] + stage1_q[11:6] + stage1_q[17:12] + stage1_q[23:18]
                + stage1_q[29:24] + {4'd0, stage1_q[31:30]};

    always_ff @(posedge clk_i) begin
        if (start_i)
            stage1_q <= sums6;
        if (stage1_vld_q)
            count_o <= fold;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage1_vld_q <= 1'b0;
            valid_o      <= 1'b0;
        end else begin
            stage1_vld_q <= start_i;
            valid_o      <= stage1_vld_q;
        end
    end

endmodule

`default_nettype wire

// File: bitmanip_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bitmanip_unit (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire                start_i,
    input  wire  bitmanip_pkg::op_e op_i,
    input  wire  [31:0]        op_a_i,
    input  wire  [31:0]        op_b_i,
    output logic [31:0]        result_o,
    output logic               done_o,
    output logic               busy_o,
    output logic [31:0]        count_in_o,
    output logic               count_start_o,
    input  wire  [5:0]         count_i,
    input  wire                count_valid_i
);

    bitmanip_pkg::op_e op_q;
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] result_q;
    logic [31:0] fast_result;
    logic        busy_q;
    logic        done_q;
    logic        counting_in;
    logic        counting_q;

    // binary search on the low half, then quarters and so on
    function automatic logic [5:0] trailing_zeros(input logic [31:0] v);
        logic [31:0] x;
        logic [5:0]  n;
        x = v;
        n = '0;
        if (x == '0)
            return 6'd32;
        if (x[15:0] == '0) begin
            n = n + 6'd16;
            x = x >> 16;
        end
        if (x[7:0] == '0) begin
            n = n + 6'd8;
            x = x >> 8;
        end
        if (x[3:0] == '0) begin
            n = n + 6'd4;
            x = x >> 4;
        end
        if (x[1:0] == '0) begin
            n = n + 6'd2;
            x = x >> 2;
        end
        if (!x[0])
            n = n + 6'd1;
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter hand-off
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign counting_in = (op_i == bitmanip_pkg::OP_HAMMING) ||
                         (op_i == bitmanip_pkg::OP_POPCOUNT);
    assign counting_q  = (op_q == bitmanip_pkg::OP_HAMMING) ||
                         (op_q == bitmanip_pkg::OP_POPCOUNT);

    // operands are held stable by the register block
    assign count_in_o    = (op_i == bitmanip_pkg::OP_HAMMING) ? (op_a_i ^ op_b_i) : op_a_i;
    assign count_start_o = start_i && counting_in;

    // single cycle ops from the latched operands
    always_comb begin
        case (op_q)
            bitmanip_pkg::OP_PACK:   fast_result = {b_q[15:0], a_q[15:0]};
            bitmanip_pkg::OP_REV8:   fast_result = {a_q[7:0], a_q[15:8], a_q[23:16], a_q[31:24]};
            bitmanip_pkg::OP_SH1ADD: fast_result = (a_q << 1) + b_q;
            bitmanip_pkg::OP_CTZ:    fast_result = {26'd0, trailing_zeros(a_q)};
            default:                 fast_result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q <= op_a_i;
            b_q <= op_b_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_q     <= bitmanip_pkg::OP_HAMMING;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                op_q   <= op_i;
                busy_q <= 1'b1;
            end else if (busy_q) begin
                if (!counting_q) begin
                    result_q <= fast_result;
                    done_q   <= 1'b1;
                    busy_q   <= 1'b0;
                end else if (count_valid_i) begin
                    result_q <= {26'd0, count_i};  // popcount fits in 6 bits
                    done_q   <= 1'b1;
                    busy_q   <= 1'b0;
                end
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;
    assign busy_o   = busy_q;

    // register block must have refused these
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        start_i |-> !busy_q);

    a_start_op_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        start_i |-> (op_i <= bitmanip_pkg::OP_CTZ));

endmodule

`default_nettype wire

// File: bitmanip_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bitmanip_regs #(
    parameter int ADDR_W = 5
) (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire                pwrite_i,
    input  wire  [ADDR_W-1:0]  paddr_i,
    input  wire  [31:0]        pwdata_i,
    output logic [31:0]        prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               start_o,
    output bitmanip_pkg::op_e  op_o,
    output logic [31:0]        op_a_o,
    output logic [31:0]        op_b_o,
    input  wire  [31:0]        result_i,
    input  wire                done_i,
    input  wire                busy_i
);

    bitmanip_pkg::ctrl_u wr_ctrl;  // pwdata seen as a control word
    bitmanip_pkg::ctrl_u rd_ctrl;
    logic        access;
    logic        wr_en;
    logic        sel_op_a;
    logic        sel_op_b;
    logic        sel_ctrl;
    logic        sel_status;
    logic        sel_result;
    logic        start_req;
    logic        op_valid;
    logic        refuse;
    logic        done_q;
    logic [31:0] status;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access     = psel_i && penable_i;  // no wait states
    assign wr_en      = access && pwrite_i;
    assign sel_op_a   = paddr_i == ADDR_W'(bitmanip_pkg::REG_OP_A);
    assign sel_op_b   = paddr_i == ADDR_W'(bitmanip_pkg::REG_OP_B);
    assign sel_ctrl   = paddr_i == ADDR_W'(bitmanip_pkg::REG_CTRL);
    assign sel_status = paddr_i == ADDR_W'(bitmanip_pkg::REG_STATUS);
    assign sel_result = paddr_i == ADDR_W'(bitmanip_pkg::REG_RESULT);

    assign wr_ctrl.raw = pwdata_i;
    assign start_req   = wr_en && sel_ctrl && wr_ctrl.f.start;
    assign op_valid    = wr_ctrl.f.op <= bitmanip_pkg::OP_CTZ;

    // start_o covers the cycle before the unit raises busy
    assign refuse = start_req && (busy_i || start_o || !op_valid);

    assign pready_o  = 1'b1;
    assign pslverr_o = refuse;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_a_o  <= '0;
            op_b_o  <= '0;
            op_o    <= bitmanip_pkg::OP_HAMMING;
            start_o <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (wr_en && sel_op_a)
                op_a_o <= pwdata_i;
            if (wr_en && sel_op_b)
                op_b_o <= pwdata_i;
            if (wr_en && sel_ctrl && !refuse)
                op_o <= wr_ctrl.f.op;
            if (start_req && !refuse) begin
                start_o <= 1'b1;
                done_q  <= 1'b0;  // new run clears old done
            end else if (done_i) begin
                done_q  <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_ctrl.raw  = '0;  // start reads back as 0
        rd_ctrl.f.op = op_o;
    end

    always_comb begin
        status = '0;
        status[bitmanip_pkg::STATUS_BUSY] = busy_i;
        status[bitmanip_pkg::STATUS_DONE] = done_q;
    end

    always_comb begin
        prdata_o = '0;
        if (sel_op_a)
            prdata_o = op_a_o;
        else if (sel_op_b)
            prdata_o = op_b_o;
        else if (sel_ctrl)
            prdata_o = rd_ctrl.raw;
        else if (sel_status)
            prdata_o = status;
        else if (sel_result)
            prdata_o = result_i;
    end

    a_prdata_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (access && !pwrite_i) |-> !$isunknown(prdata_o));

endmodule

`default_nettype wire

// File: bitmanip_top.sv
`timescale 1ns/1ps
`default_nettype none

module bitmanip_top #(
    parameter int ADDR_W = 5
) (
    input  wire               clk_i,
    input  wire               arst_n_i,
    input  wire               psel_i,
    input  wire               penable_i,
    input  wire               pwrite_i,
    input  wire  [ADDR_W-1:0] paddr_i,
    input  wire  [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

    // regs <-> unit
    logic              start;
    bitmanip_pkg::op_e op;
    logic [31:0]       op_a;
    logic [31:0]       op_b;
    logic [31:0]       result;
    logic              done;
    logic              busy;
    // unit <-> counter
    logic [31:0]       count_in;
    logic              count_start;
    logic [5:0]        count;
    logic              count_valid;

    bitmanip_regs #(
        .ADDR_W (ADDR_W)
    ) i_bitmanip_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .start_o   (start),
        .op_o      (op),
        .op_a_o    (op_a),
        .op_b_o    (op_b),
        .result_i  (result),
        .done_i    (done),
        .busy_i    (busy)
    );

    bitmanip_unit i_bitmanip_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .start_i       (start),
        .op_i          (op),
        .op_a_i        (op_a),
        .op_b_i        (op_b),
        .result_o      (result),
        .done_o        (done),
        .busy_o        (busy),
        .count_in_o    (count_in),
        .count_start_o (count_start),
        .count_i       (count),
        .count_valid_i (count_valid)
    );

    bit_count i_bit_count (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .data_i   (count_in),
        .start_i  (count_start),
        .count_o  (count),
        .valid_o  (count_valid)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;  // release away from the rising edge
    end

endmodule

`default_nettype wire

// File: bitmanip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bitmanip_tb;

    localparam int ADDR_W     = 5;
    localparam int ROUNDS     = 4;              // random passes over all six codes
    localparam int RUNS       = ROUNDS * 6 + 7;
    localparam int TRANSFERS  = RUNS * 7 + 16;  // about 7 transfers per run
    localparam int MAX_CYCLES = TRANSFERS * 12 + 10 + 100;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    // reference model state
    logic [31:0] m_a;
    logic [31:0] m_b;
    logic [2:0]  m_op;
    logic [31:0] m_prev;  // result shown until the new one lands
    logic [31:0] m_cur;
    logic        m_started;
    int          m_start_cyc;
    int          m_lat;   // edges from start to result
    int          since;
    logic        m_busy;
    logic        start_wr;
    logic        exp_slverr;
    logic [31:0] exp_status;
    logic [31:0] exp_result;
    logic [31:0] exp_rdata;
    bitmanip_pkg::ctrl_u wr_ctrl;

    logic [31:0] rng;
    int          cycles        = 0;
    int          read_errors   = 0;
    int          slverr_errors = 0;
    int          pready_errors = 0;

    tb_clock #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) i_tb_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    bitmanip_top #(
        .ADDR_W (ADDR_W)
    ) i_bitmanip_top (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] expected_result(input logic [2:0] code,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [31:0] r;
        logic [31:0] diff;
        int          i;
        r    = '0;
        diff = a ^ b;
        case (code)
            bitmanip_pkg::OP_HAMMING:
                for (i = 0; i < 32; i++)
                    r = r + 32'(diff[i]);
            bitmanip_pkg::OP_POPCOUNT:
                for (i = 0; i < 32; i++)
                    r = r + 32'(a[i]);
            bitmanip_pkg::OP_PACK:
                r = {b[15:0], a[15:0]};
            bitmanip_pkg::OP_REV8:
                for (i = 0; i < 4; i++)
                    r[8*i +: 8] = a[8*(3-i) +: 8];
            bitmanip_pkg::OP_SH1ADD:
                r = a * 32'd2 + b;
            bitmanip_pkg::OP_CTZ: begin
                r = 32'd32;
                for (i = 31; i >= 0; i--)
                    if (a[i])
                        r = i;  // lowest set bit wins
            end
            default:
                r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always_comb begin
        since  = cycles - m_start_cyc - 1;  // edges since the accepted start
        m_busy = m_started && since <= m_lat - 1;
        exp_status = '0;
        exp_status[bitmanip_pkg::STATUS_BUSY] = m_started && since >= 1 && since < m_lat;
        exp_status[bitmanip_pkg::STATUS_DONE] = m_started && since > m_lat;
        exp_result = (m_started && since >= m_lat) ? m_cur : m_prev;
        wr_ctrl.raw = pwdata;
        start_wr    = psel && penable && pwrite && wr_ctrl.f.start
                      && paddr == ADDR_W'(bitmanip_pkg::REG_CTRL);
        exp_slverr  = start_wr && (m_busy || wr_ctrl.raw[2:0] > 3'd5);
        exp_rdata   = '0;  // unmapped
        if (paddr == ADDR_W'(bitmanip_pkg::REG_OP_A))
            exp_rdata = m_a;
        else if (paddr == ADDR_W'(bitmanip_pkg::REG_OP_B))
            exp_rdata = m_b;
        else if (paddr == ADDR_W'(bitmanip_pkg::REG_CTRL))
            exp_rdata = {29'd0, m_op};
        else if (paddr == ADDR_W'(bitmanip_pkg::REG_STATUS))
            exp_rdata = exp_status;
        else if (paddr == ADDR_W'(bitmanip_pkg::REG_RESULT))
            exp_rdata = exp_result;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_a         <= '0;
            m_b         <= '0;
            m_op        <= '0;
            m_prev      <= '0;
            m_cur       <= '0;
            m_started   <= 1'b0;
            m_start_cyc <= 0;
            m_lat       <= 2;
        end else if (psel && penable && pwrite) begin
            if (paddr == ADDR_W'(bitmanip_pkg::REG_OP_A))
                m_a <= pwdata;
            if (paddr == ADDR_W'(bitmanip_pkg::REG_OP_B))
                m_b <= pwdata;
            if (paddr == ADDR_W'(bitmanip_pkg::REG_CTRL) && !exp_slverr) begin
                m_op <= pwdata[2:0];
                if (start_wr) begin
                    m_started   <= 1'b1;
                    m_start_cyc <= cycles;
                    m_lat       <= (pwdata[2:0] <= 3'd1) ? 3 : 2;  // counting ops
                    m_prev      <= exp_result;
                    m_cur       <= expected_result(pwdata[2:0], m_a, m_b);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable && !pwrite) |-> (prdata == exp_rdata))
        else begin
            read_errors = read_errors + 1;
            $display("Error at %0t: read of 0x%02h gave 0x%08h, model 0x%08h",
                     $time, $sampled(paddr), $sampled(prdata), $sampled(exp_rdata));
        end

    a_slverr: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr == exp_slverr)
        else begin
            slverr_errors = slverr_errors + 1;
            $display("Error at %0t: pslverr %0b on 0x%02h, model %0b",
                     $time, $sampled(pslverr), $sampled(paddr), $sampled(exp_slverr));
        end

    a_pready: assert property (@(posedge clk) disable iff (!arst_n) pready)
        else begin
            pready_errors = pready_errors + 1;
            $display("Error at %0t: pready low", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= ADDR_W'(addr);
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= ADDR_W'(addr);
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;  // mid access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_op(input logic [2:0] code);
        bitmanip_pkg::ctrl_u c;
        c.raw     = '0;
        c.f.start = 1'b1;
        c.f.op    = bitmanip_pkg::op_e'(code);
        apb_write(bitmanip_pkg::REG_CTRL, c.raw);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[bitmanip_pkg::STATUS_DONE])
            apb_read(bitmanip_pkg::REG_STATUS, st);
    endtask

    task automatic run_op(input logic [2:0] code, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] rd;
        apb_write(bitmanip_pkg::REG_OP_A, a);
        apb_write(bitmanip_pkg::REG_OP_B, b);
        start_op(code);
        wait_done();
        apb_read(bitmanip_pkg::REG_RESULT, rd);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        int          r;
        int          code;
        rng     = 32'd64;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        wait (arst_n === 1'b1);

        // reset values
        apb_read(bitmanip_pkg::REG_OP_A, rd);
        apb_read(bitmanip_pkg::REG_OP_B, rd);
        apb_read(bitmanip_pkg::REG_CTRL, rd);
        apb_read(bitmanip_pkg::REG_STATUS, rd);
        apb_read(bitmanip_pkg::REG_RESULT, rd);
        apb_read(8'h14, rd);  // unmapped offset reads zero

        for (r = 0; r < ROUNDS; r++) begin
            for (code = 0; code < 6; code++) begin
                rng = xorshift(rng);
                a   = rng;
                rng = xorshift(rng);
                b   = rng;
                run_op(3'(code), a, b);
            end
        end

        // edge operands
        run_op(bitmanip_pkg::OP_CTZ, 32'h0000_0000, 32'h0);
        run_op(bitmanip_pkg::OP_CTZ, 32'hffff_ffff, 32'h0);
        run_op(bitmanip_pkg::OP_POPCOUNT, 32'h0000_0000, 32'h0);
        run_op(bitmanip_pkg::OP_POPCOUNT, 32'hffff_ffff, 32'h0);
        run_op(bitmanip_pkg::OP_HAMMING, 32'h5a5a_c3c3, 32'h5a5a_c3c3);

        // invalid codes refused with done kept
        start_op(3'd6);
        apb_read(bitmanip_pkg::REG_STATUS, rd);
        start_op(3'd7);
        apb_read(bitmanip_pkg::REG_STATUS, rd);

        // second start while the counter is busy
        apb_write(bitmanip_pkg::REG_OP_A, 32'h8000_0f01);
        start_op(bitmanip_pkg::OP_POPCOUNT);
        start_op(bitmanip_pkg::OP_SH1ADD);
        wait_done();
        apb_read(bitmanip_pkg::REG_RESULT, rd);

        // readback where the start bit reads 0
        run_op(bitmanip_pkg::OP_REV8, 32'h1234_5678, 32'h9abc_def0);
        apb_read(bitmanip_pkg::REG_OP_A, rd);
        apb_read(bitmanip_pkg::REG_OP_B, rd);
        apb_read(bitmanip_pkg::REG_CTRL, rd);
        apb_write(bitmanip_pkg::REG_CTRL, {29'd0, bitmanip_pkg::OP_PACK});
        apb_read(bitmanip_pkg::REG_CTRL, rd);

        repeat (2) @(posedge clk);
        $display("Summary: read mismatches %0d, pslverr mismatches %0d, pready faults %0d",
                 read_errors, slverr_errors, pready_errors);
        if (read_errors == 0 && slverr_errors == 0 && pready_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bitmanip_top.f
bitmanip_pkg.sv
bit_count.sv
bitmanip_unit.sv
bitmanip_regs.sv
bitmanip_top.sv
tb_clock.sv
bitmanip_tb.sv

// File: Makefile
TOP := bitmanip_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f bitmanip_top.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
